/* vlog.f */
+incdir+dv
design/simd_alu_pkg.sv
design/simd_op_decode.sv
design/simd_byte_lane.sv
design/simd_result_stage.sv
design/simd_alu.sv
dv/simd_alu_tb.sv

/* Makefile */
# Verilator build and run of the SIMD ALU testbench

VERILATOR ?= verilator
TOP       ?= simd_alu_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS)
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

# build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "sim: pass line found in $(LOG)"; \
	else \
		echo "sim: pass line missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/simd_alu_model.svh */
// reference model functions: element width, element relation, expected result word and compare flag
`ifndef SIMD_ALU_MODEL_SVH
`define SIMD_ALU_MODEL_SVH

// element size in bits for a vector mode
function automatic int unsigned elem_width(vec_mode_e mode);
  case (mode)
    VEC_MODE16: return 16;
    VEC_MODE8:  return 8;
    default:    return 32;
  endcase
endfunction

// two's complement value of a w-bit element held zero-extended
function automatic longint to_signed(longint v, int unsigned w);
  if (v[w-1]) begin
    return v - (longint'(1) << w);
  end
  return v;
endfunction

// relation for compares, for min/max whether a is the element to keep
function automatic bit elem_holds(alu_op_e op, longint ua, longint ub, int unsigned w);
  longint sa;
  longint sb;
  sa = to_signed(ua, w);
  sb = to_signed(ub, w);
  case (op)
    ALU_NE:   return ua != ub;
    ALU_GTS:  return sa > sb;
    ALU_GTU:  return ua > ub;
    ALU_GES:  return sa >= sb;
    ALU_GEU:  return ua >= ub;
    ALU_LTS:  return sa < sb;
    ALU_LTU:  return ua < ub;
    ALU_LES:  return sa <= sb;
    ALU_LEU:  return ua <= ub;
    // equal elements give the same value either way
    ALU_MIN:  return sa < sb;
    ALU_MINU: return ua < ub;
    ALU_MAX:  return sa > sb;
    ALU_MAXU: return ua > ub;
    default:  return ua == ub;
  endcase
endfunction

// expected result word, element by element
function automatic word_t model_result(alu_op_e op, vec_mode_e mode, word_t a, word_t b);
  int unsigned w;
  longint      mask_w;
  longint      ua;
  longint      ub;
  longint      r;
  word_t       res;
  w      = elem_width(mode);
  mask_w = (longint'(1) << w) - 1;
  res    = '0;
  for (int e = 0; e < XLEN / w; e++) begin
    ua = longint'(a >> (e * w)) & mask_w;
    ub = longint'(b >> (e * w)) & mask_w;
    case (op)
      ALU_ADD: r = ua + ub;
      // wraps modulo the element width after masking
      ALU_SUB: r = ua - ub;
      ALU_AND: r = ua & ub;
      ALU_OR:  r = ua | ub;
      ALU_XOR: r = ua ^ ub;
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU: r = elem_holds(op, ua, ub, w) ? ua : ub;
      default: r = elem_holds(op, ua, ub, w) ? mask_w : 64'd0;
    endcase
    res = res | (word_t'(r & mask_w) << (e * w));
  end
  return res;
endfunction

// scalar flag: top element's relation, or its equality outside compares
function automatic bit model_cmp(alu_op_e op, vec_mode_e mode, word_t a, word_t b);
  int unsigned w;
  longint      ua;
  longint      ub;
  w  = elem_width(mode);
  ua = longint'(a >> (XLEN - w)) & ((longint'(1) << w) - 1);
  ub = longint'(b >> (XLEN - w)) & ((longint'(1) << w) - 1);
  case (op)
    ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
    ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU: return elem_holds(op, ua, ub, w);
    default: return ua == ub;
  endcase
endfunction

`endif

/* dv/simd_alu_tb.sv */
// testbench: clock, reset, random requests, expected-value queue, handshake and result checks
`timescale 1ns/1ps

module simd_alu_tb;
  import simd_alu_pkg::*;

  `include "simd_alu_model.svh"

  localparam int unsigned NUM_TESTS      = 3000;
  localparam int unsigned SEED           = 97;
  localparam int unsigned CLK_PERIOD     = 10;
  localparam int unsigned RESET_CYCLES   = 5;
  localparam int unsigned TIMEOUT_MARGIN = 200;
  localparam int unsigned DRAIN_LIMIT    = 20;

  // one expected output, with its request for messages
  typedef struct packed {
    word_t     result;
    logic      cmp;
    alu_op_e   op;
    vec_mode_e mode;
    word_t     a;
    word_t     b;
  } exp_t;

  logic      clk_i;
  logic      arst_n_i;
  logic      in_valid_i;
  logic      in_ready_o;
  alu_op_e   op_i;
  vec_mode_e vec_mode_i;
  word_t     operand_a_i;
  word_t     operand_b_i;
  logic      out_valid_o;
  logic      out_ready_i;
  word_t     result_o;
  logic      cmp_o;

  exp_t        exp_q[$];
  int unsigned accepted;
  int unsigned drain;
  int unsigned mismatch_errors;
  int unsigned handshake_errors;
  int unsigned other_errors;
  logic        in_fire;

  simd_alu UUT (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_i        (op_i),
    .vec_mode_i  (vec_mode_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .cmp_o       (cmp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // hard stop, about 20 cycles per request is far more than needed
  initial begin
    #(CLK_PERIOD * (NUM_TESTS * 20 + TIMEOUT_MARGIN));
    $display("watchdog expired after %0d requests accepted, run did not finish", accepted);
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // new random request, b often shares bytes with a to hit equal lanes
  task automatic new_request();
    logic [4:0] op_code;
    op_code = 5'($urandom_range(0, 18));
    op_i    = alu_op_e'(op_code);
    case ($urandom_range(0, 2))
      0:       vec_mode_i = VEC_MODE32;
      1:       vec_mode_i = VEC_MODE16;
      default: vec_mode_i = VEC_MODE8;
    endcase
    operand_a_i = $urandom();
    operand_b_i = $urandom();
    if ($urandom_range(0, 2) == 0) begin
      operand_b_i = operand_a_i;
      for (int i = 0; i < NUM_LANES; i++) begin
        if ($urandom_range(0, 1) == 1) begin
          operand_b_i[i*LANE_W +: LANE_W] = 8'($urandom());
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks, run after the falling-edge drive has settled
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_cycle();
    exp_t exp;
    // output register is full exactly while an accepted request is pending
    assert (out_valid_o == (exp_q.size() != 0)) else begin
      handshake_errors++;
      if (out_valid_o) $display("%0t: output valid with no accepted request pending", $time);
      else $display("%0t: accepted request not on the output one cycle later", $time);
    end
    assert (in_ready_o == ((exp_q.size() == 0) || out_ready_i)) else begin
      handshake_errors++;
      $display("%0t: input ready wrong for output state and out_ready", $time);
    end
    if (out_valid_o && exp_q.size() != 0) begin
      // compared every valid cycle, so a stalled word must hold
      exp = exp_q[0];
      assert (result_o == exp.result) else begin
        mismatch_errors++;
        $display("Mismatch at %0t: op %0d mode %0d a %h b %h result %h expected %h",
                 $time, exp.op, exp.mode, exp.a, exp.b, result_o, exp.result);
      end
      assert (cmp_o == exp.cmp) else begin
        mismatch_errors++;
        $display("Mismatch at %0t: op %0d mode %0d a %h b %h cmp %b expected %b",
                 $time, exp.op, exp.mode, exp.a, exp.b, cmp_o, exp.cmp);
      end
      if (out_ready_i) void'(exp_q.pop_front());
    end
    in_fire = in_valid_i && in_ready_o;
    if (in_fire) begin
      exp.result = model_result(op_i, vec_mode_i, operand_a_i, operand_b_i);
      exp.cmp    = model_cmp(op_i, vec_mode_i, operand_a_i, operand_b_i);
      exp.op     = op_i;
      exp.mode   = vec_mode_i;
      exp.a      = operand_a_i;
      exp.b      = operand_b_i;
      exp_q.push_back(exp);
      accepted++;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    arst_n_i         = 1'b0;
    in_valid_i       = 1'b0;
    op_i             = ALU_ADD;
    vec_mode_i       = VEC_MODE32;
    operand_a_i      = '0;
    operand_b_i      = '0;
    out_ready_i      = 1'b0;
    in_fire          = 1'b0;
    accepted         = 0;
    drain            = 0;
    mismatch_errors  = 0;
    handshake_errors = 0;
    other_errors     = 0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    arst_n_i = 1'b1;
    while (accepted < NUM_TESTS || (exp_q.size() != 0 && drain < DRAIN_LIMIT)) begin
      @(negedge clk_i);
      // request held until taken
      if (in_fire) in_valid_i = 1'b0;
      if (!in_valid_i && accepted < NUM_TESTS && $urandom_range(0, 3) != 0) begin
        new_request();
        in_valid_i = 1'b1;
      end
      // back-pressure a quarter of the time, none while draining
      out_ready_i = ($urandom_range(0, 3) != 0) || (accepted >= NUM_TESTS);
      if (accepted >= NUM_TESTS) drain++;
      #1;
      check_cycle();
    end
    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("%0d accepted requests never left the output register", exp_q.size());
    end
    $display("errors: %0d mismatches, %0d handshake, %0d other, %0d requests checked",
             mismatch_errors, handshake_errors, other_errors, accepted);
    if (mismatch_errors + handshake_errors + other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* design/simd_alu.sv */
// top level: decoder, generate loop of carry-chained byte lanes, registered result stage
`timescale 1ns/1ps

module simd_alu (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // request side
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  simd_alu_pkg::alu_op_e   op_i,
  input  simd_alu_pkg::vec_mode_e vec_mode_i,
  input  simd_alu_pkg::word_t     operand_a_i,
  input  simd_alu_pkg::word_t     operand_b_i,
  // response side
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output simd_alu_pkg::word_t     result_o,
  output logic                    cmp_o
);
  import simd_alu_pkg::*;

  // decoder controls
  logic       negate_b;
  lane_mask_t carry_break;
  lane_mask_t lane_signed;
  logic       do_min;
  logic [2:0] cmp_sel;
  logic [1:0] result_sel;

  // lane outputs
  word_t      sum;
  lane_mask_t lane_eq;
  lane_mask_t lane_gt;
  // carry out of each lane and carry into each lane
  lane_mask_t carry_out;
  lane_mask_t carry_in;

  simd_op_decode u_decode (
    .op_i          (op_i),
    .vec_mode_i    (vec_mode_i),
    .negate_b_o    (negate_b),
    .carry_break_o (carry_break),
    .lane_signed_o (lane_signed),
    .do_min_o      (do_min),
    .cmp_sel_o     (cmp_sel),
    .result_sel_o  (result_sel)
  );

  ////////////////////////////////////////////////////////////////////////////
  // partitioned adder and comparator lanes
  ////////////////////////////////////////////////////////////////////////////

  // lane 0 always breaks, so its chain input is a constant
  assign carry_in = {carry_out[NUM_LANES-2:0], 1'b0};

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    simd_byte_lane u_lane (
      .a_i        (operand_a_i[i*LANE_W +: LANE_W]),
      .b_i        (operand_b_i[i*LANE_W +: LANE_W]),
      .negate_b_i (negate_b),
      .break_i    (carry_break[i]),
      .signed_i   (lane_signed[i]),
      .carry_i    (carry_in[i]),
      .sum_o      (sum[i*LANE_W +: LANE_W]),
      .carry_o    (carry_out[i]),
      .eq_o       (lane_eq[i]),
      .gt_o       (lane_gt[i])
    );
  end

  simd_result_stage u_result (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .vec_mode_i   (vec_mode_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .sum_i        (sum),
    .eq_i         (lane_eq),
    .gt_i         (lane_gt),
    .do_min_i     (do_min),
    .cmp_sel_i    (cmp_sel),
    .result_sel_i (result_sel),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .result_o     (result_o),
    .cmp_o        (cmp_o)
  );

endmodule

/* design/simd_result_stage.sv */
// result stage: element flag merge, compare relation, min/max select, result mux, output register
`timescale 1ns/1ps

module simd_result_stage (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  simd_alu_pkg::vec_mode_e  vec_mode_i,
  input  simd_alu_pkg::word_t      operand_a_i,
  input  simd_alu_pkg::word_t      operand_b_i,
  input  simd_alu_pkg::word_t      sum_i,
  input  simd_alu_pkg::lane_mask_t eq_i,
  input  simd_alu_pkg::lane_mask_t gt_i,
  input  logic                     do_min_i,
  input  logic [2:0]               cmp_sel_i,
  input  logic [1:0]               result_sel_i,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output simd_alu_pkg::word_t      result_o,
  output logic                     cmp_o
);
  import simd_alu_pkg::*;

  // per-element flags spread over the element's lanes
  lane_mask_t elem_eq;
  lane_mask_t elem_gt;
  lane_mask_t rel_mask;
  lane_mask_t sel_minmax;
  word_t      logic_res;
  word_t      cmp_res;
  word_t      minmax_res;
  word_t      result_d;
  logic       cmp_d;
  logic       load;

  ////////////////////////////////////////////////////////////////////////////
  // element flags
  ////////////////////////////////////////////////////////////////////////////

  // greater: higher byte greater, or equal with the lower bytes greater
  always_comb begin
    case (vec_mode_i)
      VEC_MODE8: begin
        elem_eq = eq_i;
        elem_gt = gt_i;
      end
      VEC_MODE16: begin
        elem_eq[1:0] = {2{eq_i[1] & eq_i[0]}};
        elem_eq[3:2] = {2{eq_i[3] & eq_i[2]}};
        elem_gt[1:0] = {2{gt_i[1] | (eq_i[1] & gt_i[0])}};
        elem_gt[3:2] = {2{gt_i[3] | (eq_i[3] & gt_i[2])}};
      end
      default: begin
        elem_eq = {NUM_LANES{&eq_i}};
        elem_gt = {NUM_LANES{gt_i[3] | (eq_i[3] & (gt_i[2] |
                             (eq_i[2] & (gt_i[1] | (eq_i[1] & gt_i[0])))))}};
      end
    endcase
  end

  // relation under test
  always_comb begin
    case (cmp_sel_i)
      CMP_NE:  rel_mask = ~elem_eq;
      CMP_GT:  rel_mask = elem_gt;
      CMP_GE:  rel_mask = elem_gt | elem_eq;
      CMP_LT:  rel_mask = ~(elem_gt | elem_eq);
      CMP_LE:  rel_mask = ~elem_gt;
      default: rel_mask = elem_eq;
    endcase
  end

  // pick a where a > b for max, where a <= b for min
  assign sel_minmax = elem_gt ^ {NUM_LANES{do_min_i}};

  ////////////////////////////////////////////////////////////////////////////
  // result sources
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (cmp_sel_i)
      LOGIC_OR:  logic_res = operand_a_i | operand_b_i;
      LOGIC_XOR: logic_res = operand_a_i ^ operand_b_i;
      default:   logic_res = operand_a_i & operand_b_i;
    endcase
  end

  // byte-wise fill and select
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      cmp_res[i*LANE_W +: LANE_W]    = {LANE_W{rel_mask[i]}};
      minmax_res[i*LANE_W +: LANE_W] = sel_minmax[i] ? operand_a_i[i*LANE_W +: LANE_W]
                                                     : operand_b_i[i*LANE_W +: LANE_W];
    end
  end

  always_comb begin
    case (result_sel_i)
      RES_LOGIC:  result_d = logic_res;
      RES_CMP:    result_d = cmp_res;
      RES_MINMAX: result_d = minmax_res;
      default:    result_d = sum_i;
    endcase
  end

  // scalar flag from the top element, equality outside compares
  assign cmp_d = (result_sel_i == RES_CMP) ? rel_mask[NUM_LANES-1] : elem_eq[NUM_LANES-1];

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  // take a new word when empty or when the held one leaves this cycle
  assign in_ready_o = ~out_valid_o | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      result_o <= result_d;
      cmp_o    <= cmp_d;
    end
  end

  // a stalled word stays put until the consumer takes it
  hold_under_stall: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(cmp_o)
  ) else $error("simd_result_stage: output changed under back-pressure");

endmodule

/* design/simd_byte_lane.sv */
// byte lane: 8-bit slice of the partitioned adder and byte comparator
`timescale 1ns/1ps

module simd_byte_lane (
  input  simd_alu_pkg::lane_t a_i,
  input  simd_alu_pkg::lane_t b_i,
  input  logic                negate_b_i,
  input  logic                break_i,
  input  logic                signed_i,
  input  logic                carry_i,
  output simd_alu_pkg::lane_t sum_o,
  output logic                carry_o,
  output logic                eq_o,
  output logic                gt_o
);
  import simd_alu_pkg::*;

  // adder operand b, inverted for subtract
  lane_t           b_op;
  logic            carry_in;
  // sum with the carry out on top
  logic [LANE_W:0] sum_ext;
  // comparator operands, 9 bits with optional sign extension
  logic [LANE_W:0] a_cmp;
  logic [LANE_W:0] b_cmp;

  ////////////////////////////////////////////////////////////////////////////
  // adder slice
  ////////////////////////////////////////////////////////////////////////////

  assign b_op = negate_b_i ? ~b_i : b_i;

  // a new element seeds its own carry
  // one completes the two's complement on subtract
  assign carry_in = break_i ? negate_b_i : carry_i;

  assign sum_ext = {1'b0, a_i} + {1'b0, b_op} + {{LANE_W{1'b0}}, carry_in};
  assign sum_o   = sum_ext[LANE_W-1:0];
  assign carry_o = sum_ext[LANE_W];

  ////////////////////////////////////////////////////////////////////////////
  // comparator
  ////////////////////////////////////////////////////////////////////////////

  assign eq_o = (a_i == b_i);

  // sign bit only extended on an element's top byte under a signed op,
  // lower bytes of a wide element always compare unsigned
  assign a_cmp = {a_i[LANE_W-1] & signed_i, a_i};
  assign b_cmp = {b_i[LANE_W-1] & signed_i, b_i};

  assign gt_o = ($signed(a_cmp) > $signed(b_cmp));

endmodule

/* design/simd_op_decode.sv */
// operation decoder: adder negate, carry-break and signed lane masks, compare and result selects
`timescale 1ns/1ps

module simd_op_decode (
  input  simd_alu_pkg::alu_op_e    op_i,
  input  simd_alu_pkg::vec_mode_e  vec_mode_i,
  output logic                     negate_b_o,
  output simd_alu_pkg::lane_mask_t carry_break_o,
  output simd_alu_pkg::lane_mask_t lane_signed_o,
  output logic                     do_min_o,
  output logic [2:0]               cmp_sel_o,
  output logic [1:0]               result_sel_o
);
  import simd_alu_pkg::*;

  // set for signed compares and signed min/max
  logic       signed_op;
  // cleared when op_i decodes to nothing
  logic       op_known;
  // lanes holding the top byte of an element
  lane_mask_t elem_top;

  ////////////////////////////////////////////////////////////////////////////
  // element partitioning
  ////////////////////////////////////////////////////////////////////////////

  // break lanes start an element, top lanes end one
  always_comb begin
    case (vec_mode_i)
      VEC_MODE16: begin
        carry_break_o = 4'b0101;
        elem_top      = 4'b1010;
      end
      VEC_MODE8: begin
        carry_break_o = 4'b1111;
        elem_top      = 4'b1111;
      end
      default: begin
        // one 32-bit element
        carry_break_o = 4'b0001;
        elem_top      = 4'b1000;
      end
    endcase
  end

  // only the sign byte of an element is extended in the comparator
  assign lane_signed_o = signed_op ? elem_top : '0;

  ////////////////////////////////////////////////////////////////////////////
  // operation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    negate_b_o   = 1'b0;
    do_min_o     = 1'b0;
    signed_op    = 1'b0;
    cmp_sel_o    = CMP_EQ;
    result_sel_o = RES_SUM;
    op_known     = 1'b1;
    case (op_i)
      ALU_ADD:  ;
      // a + ~b + 1
      ALU_SUB:  negate_b_o = 1'b1;
      ALU_AND:  begin result_sel_o = RES_LOGIC; cmp_sel_o = LOGIC_AND; end
      ALU_OR:   begin result_sel_o = RES_LOGIC; cmp_sel_o = LOGIC_OR;  end
      ALU_XOR:  begin result_sel_o = RES_LOGIC; cmp_sel_o = LOGIC_XOR; end
      ALU_EQ:   result_sel_o = RES_CMP;
      ALU_NE:   begin result_sel_o = RES_CMP; cmp_sel_o = CMP_NE; end
      ALU_GTS:  begin result_sel_o = RES_CMP; cmp_sel_o = CMP_GT; signed_op = 1'b1; end
      ALU_GTU:  begin result_sel_o = RES_CMP; cmp_sel_o = CMP_GT; end
      ALU_GES:  begin result_sel_o = RES_CMP; cmp_sel_o = CMP_GE; signed_op = 1'b1; end
      ALU_GEU:  begin result_sel_o = RES_CMP; cmp_sel_o = CMP_GE; end
      ALU_LTS:  begin result_sel_o = RES_CMP; cmp_sel_o = CMP_LT; signed_op = 1'b1; end
      ALU_LTU:  begin result_sel_o = RES_CMP; cmp_sel_o = CMP_LT; end
      ALU_LES:  begin result_sel_o = RES_CMP; cmp_sel_o = CMP_LE; signed_op = 1'b1; end
      ALU_LEU:  begin result_sel_o = RES_CMP; cmp_sel_o = CMP_LE; end
      // min flips the greater-than select
      ALU_MIN:  begin result_sel_o = RES_MINMAX; do_min_o = 1'b1; signed_op = 1'b1; end
      ALU_MINU: begin result_sel_o = RES_MINMAX; do_min_o = 1'b1; end
      ALU_MAX:  begin result_sel_o = RES_MINMAX; signed_op = 1'b1; end
      ALU_MAXU: result_sel_o = RES_MINMAX;
      default:  op_known = 1'b0;
    endcase
  end

  // an encoding outside alu_op_e would silently act as add
  always_comb begin
    op_known_chk: assert final (op_known)
      else $error("simd_op_decode: unknown operation code %0d", op_i);
  end

endmodule

/* design/simd_alu_pkg.sv */
// widths, vector typedefs, operation and vector-mode enums, decoder control codes
package simd_alu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // one rv32 register
  localparam int unsigned XLEN      = 32;
  // partitioned adder and comparator work on bytes
  localparam int unsigned LANE_W    = 8;
  localparam int unsigned NUM_LANES = XLEN / LANE_W;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [LANE_W-1:0]    lane_t;
  // one bit per byte lane, lane 0 is the low byte
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  ////////////////////////////////////////////////////////////////////////////
  // operations and vector modes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    // compares, result is an element mask
    ALU_EQ   = 5'd5,
    ALU_NE   = 5'd6,
    ALU_GTS  = 5'd7,
    ALU_GTU  = 5'd8,
    ALU_GES  = 5'd9,
    ALU_GEU  = 5'd10,
    ALU_LTS  = 5'd11,
    ALU_LTU  = 5'd12,
    ALU_LES  = 5'd13,
    ALU_LEU  = 5'd14,
    // lane-wise min and max
    ALU_MIN  = 5'd15,
    ALU_MINU = 5'd16,
    ALU_MAX  = 5'd17,
    ALU_MAXU = 5'd18
  } alu_op_e;

  // element size, 2'b01 is not a mode
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  ////////////////////////////////////////////////////////////////////////////
  // decoder to result stage control codes
  ////////////////////////////////////////////////////////////////////////////

  // cmp_sel under a compare: relation applied to the element flags
  localparam logic [2:0] CMP_EQ = 3'd0;
  localparam logic [2:0] CMP_NE = 3'd1;
  localparam logic [2:0] CMP_GT = 3'd2;
  localparam logic [2:0] CMP_GE = 3'd3;
  localparam logic [2:0] CMP_LT = 3'd4;
  localparam logic [2:0] CMP_LE = 3'd5;

  // cmp_sel under a bitwise op: which logic function
  localparam logic [2:0] LOGIC_AND = 3'd0;
  localparam logic [2:0] LOGIC_OR  = 3'd1;
  localparam logic [2:0] LOGIC_XOR = 3'd2;

  // result source
  localparam logic [1:0] RES_SUM    = 2'd0;
  localparam logic [1:0] RES_LOGIC  = 2'd1;
  localparam logic [1:0] RES_CMP    = 2'd2;
  localparam logic [1:0] RES_MINMAX = 2'd3;

endpackage
